/* rtl/cfg_defs.svh */
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

////////////////////////////////////////
// Register bus geometry
////////////////////////////////////////

`define CFG_ADDR_W      14           // Byte address
`define CFG_DATA_W      32           // One bus word
`define CFG_BE_W        4            // One enable per byte lane

////////////////////////////////////////
// Reset stretchers
////////////////////////////////////////

`define RST_CNT_W       8            // Counter and delay width
`define RST_DOM_NUM     4            // dsp, all, mac, mm
`define RST_DELAY_DEF   16           // Delay after power-on

////////////////////////////////////////
// Register map, byte addresses
////////////////////////////////////////

`define REG_VERSION     14'h000      // RO version input
`define REG_CTRL        14'h004      // Eth enables, mode, board id
`define REG_RST_DELAY   14'h008      // Shared stretch delay
`define REG_RST_CMD     14'h00C      // WO, one bit per domain
`define REG_DROP_CNT    14'h010      // RO drop counter input
`define REG_TEST        14'h014      // Scratch word

// Lanes of one bus word
`define CFG_LANE_W      8

`endif

/* rtl/cfg_reg_pkg.sv */
`default_nettype none

`include "cfg_defs.svh"

package cfg_reg_pkg;

  // Raw bus word
  typedef logic [`CFG_DATA_W-1:0] cfg_word_t;

  // Control word as decoded fields, MSB first
  typedef struct packed {
    logic [15:0] board_id;       // Bits 31..16
    logic [7:0]  rsvd_hi;        // Bits 15..8, stored, no function
    logic [3:0]  mode_sel;       // Bits 7..4
    logic [1:0]  rsvd_lo;        // Bits 3..2
    logic        eth_rx_enable;  // Bit 1
    logic        eth_tx_enable;  // Bit 0
  } cfg_ctrl_fields_t;

  // Control register seen both ways
  typedef union packed {
    cfg_word_t        word;      // Byte-lane writes and readback
    cfg_ctrl_fields_t fields;    // Field outputs
  } cfg_ctrl_u;

endpackage

`default_nettype wire

/* rtl/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_defs.svh"

module cfg_regs (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    reg_wr_en,             // Single-cycle strobe
  input  wire logic                    reg_rd_en,             // Single-cycle strobe
  input  wire logic [`CFG_ADDR_W-1:0]  reg_addr,
  input  wire cfg_reg_pkg::cfg_word_t  reg_wr_data,
  input  wire logic [`CFG_BE_W-1:0]    reg_byte_enable,
  input  wire cfg_reg_pkg::cfg_word_t  params_version_num_ro,
  input  wire cfg_reg_pkg::cfg_word_t  drop_pkt_cnt,
  output cfg_reg_pkg::cfg_word_t       reg_rd_data,
  output logic                         reg_rd_data_vld,       // One cycle per read
  output logic                         eth_tx_enable,
  output logic                         eth_rx_enable,
  output logic [3:0]                   params_mode_sel,
  output logic [15:0]                  params_board_id,
  output cfg_reg_pkg::cfg_word_t       params_test,
  output logic [`RST_DOM_NUM-1:0]      soft_rst,              // One-cycle pulses
  output rst_ctrl_pkg::rst_cnt_t       rst_delay
);

  import cfg_reg_pkg::*;
  import rst_ctrl_pkg::*;

  cfg_ctrl_u ctrl_q;                   // Control word
  cfg_word_t rd_mux;                   // Read data before the output flop
  logic      wr_ctrl;
  logic      wr_delay;
  logic      wr_cmd;
  logic      wr_test;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  assign wr_ctrl  = reg_wr_en && (reg_addr == `REG_CTRL);
  assign wr_delay = reg_wr_en && (reg_addr == `REG_RST_DELAY);
  assign wr_cmd   = reg_wr_en && (reg_addr == `REG_RST_CMD);
  assign wr_test  = reg_wr_en && (reg_addr == `REG_TEST);   // Other addresses dropped

  // Control and scratch words, lane by lane
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q.word <= '0;                                     // Eth off, mode 0, id 0
      params_test <= '0;
    end else begin
      for (int i = 0; i < `CFG_BE_W; i++) begin
        if (wr_ctrl && reg_byte_enable[i]) begin
          ctrl_q.word[i*`CFG_LANE_W +: `CFG_LANE_W] <= reg_wr_data[i*`CFG_LANE_W +: `CFG_LANE_W];
        end
        if (wr_test && reg_byte_enable[i]) begin
          params_test[i*`CFG_LANE_W +: `CFG_LANE_W] <= reg_wr_data[i*`CFG_LANE_W +: `CFG_LANE_W];
        end
      end
    end
  end

  // Delay lives in lane 0 only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_delay <= rst_cnt_t'(`RST_DELAY_DEF);
    end else if (wr_delay && reg_byte_enable[0]) begin
      rst_delay <= rst_cnt_t'(reg_wr_data);                  // Upper lanes ignored
    end
  end

  // Command write becomes a pulse on the following cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      soft_rst <= '0;
    end else if (wr_cmd && reg_byte_enable[0]) begin
      soft_rst <= reg_wr_data[`RST_DOM_NUM-1:0];             // Bit k hits domain k
    end else begin
      soft_rst <= '0;                                        // Self-clearing
    end
  end

  ////////////////////////////////////////
  // Field outputs
  ////////////////////////////////////////

  assign eth_tx_enable   = ctrl_q.fields.eth_tx_enable;
  assign eth_rx_enable   = ctrl_q.fields.eth_rx_enable;
  assign params_mode_sel = ctrl_q.fields.mode_sel;
  assign params_board_id = ctrl_q.fields.board_id;

  ////////////////////////////////////////
  // Read path, one cycle latency
  ////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      `REG_VERSION:   rd_mux = params_version_num_ro;
      `REG_CTRL:      rd_mux = ctrl_q.word;                  // Reserved bits read back too
      `REG_RST_DELAY: rd_mux = cfg_word_t'(rst_delay);       // Zero-extended
      `REG_RST_CMD:   rd_mux = '0;                           // Write-only
      `REG_DROP_CNT:  rd_mux = drop_pkt_cnt;
      `REG_TEST:      rd_mux = params_test;
      default:        rd_mux = '0;                           // Unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_rd_data_vld <= 1'b0;
    end else begin
      reg_rd_data_vld <= reg_rd_en;                          // No back-pressure
    end
  end

  always_ff @(posedge clk) begin
    if (reg_rd_en) begin
      reg_rd_data <= rd_mux;                                 // Held until next read
    end
  end

endmodule

`default_nettype wire

/* rtl/cfg_top_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_defs.svh"

module cfg_top_wrapper (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    reg_wr_en,
  input  wire logic                    reg_rd_en,
  input  wire logic [`CFG_ADDR_W-1:0]  reg_addr,
  input  wire cfg_reg_pkg::cfg_word_t  reg_wr_data,
  input  wire logic [`CFG_BE_W-1:0]    reg_byte_enable,
  input  wire cfg_reg_pkg::cfg_word_t  params_version_num_ro,   // Build version
  input  wire cfg_reg_pkg::cfg_word_t  drop_pkt_cnt,            // From the MAC
  output cfg_reg_pkg::cfg_word_t       reg_rd_data,
  output logic                         reg_rd_data_vld,
  output logic                         params_dsp_rst,
  output logic                         params_all_rst,
  output logic                         params_mac_rst,
  output logic                         params_mm_rst,
  output logic                         eth_tx_enable,
  output logic                         eth_rx_enable,
  output logic [3:0]                   params_mode_sel,
  output logic [15:0]                  params_board_id,
  output cfg_reg_pkg::cfg_word_t       params_test
);

  import rst_ctrl_pkg::*;

  logic [`RST_DOM_NUM-1:0] soft_rst;    // Pulses from command writes
  logic [`RST_DOM_NUM-1:0] dom_rst;     // Stretched levels
  rst_cnt_t                rst_delay;   // Common to all domains

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  cfg_regs u_cfg_regs (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .reg_wr_en             (reg_wr_en),
    .reg_rd_en             (reg_rd_en),
    .reg_addr              (reg_addr),
    .reg_wr_data           (reg_wr_data),
    .reg_byte_enable       (reg_byte_enable),
    .params_version_num_ro (params_version_num_ro),
    .drop_pkt_cnt          (drop_pkt_cnt),
    .reg_rd_data           (reg_rd_data),
    .reg_rd_data_vld       (reg_rd_data_vld),
    .eth_tx_enable         (eth_tx_enable),
    .eth_rx_enable         (eth_rx_enable),
    .params_mode_sel       (params_mode_sel),
    .params_board_id       (params_board_id),
    .params_test           (params_test),
    .soft_rst              (soft_rst),
    .rst_delay             (rst_delay)
  );

  ////////////////////////////////////////
  // One stretcher per reset domain
  ////////////////////////////////////////

  for (genvar d = int'(RST_DSP); d <= int'(RST_MM); d++) begin : g_rst_dom
    rst_stretch u_rst_stretch (
      .clk     (clk),
      .rst_n   (rst_n),
      .trig    (soft_rst[d]),                // Command bit d
      .delay   (rst_delay),
      .rst_out (dom_rst[d])
    );
  end

  assign params_dsp_rst = dom_rst[RST_DSP];
  assign params_all_rst = dom_rst[RST_ALL];
  assign params_mac_rst = dom_rst[RST_MAC];
  assign params_mm_rst  = dom_rst[RST_MM];

endmodule

`default_nettype wire

/* rtl/rst_ctrl_pkg.sv */
`default_nettype none

`include "cfg_defs.svh"

package rst_ctrl_pkg;

  // Domain index, also bit position in the command word
  typedef enum logic [$clog2(`RST_DOM_NUM)-1:0] {
    RST_DSP = 0,
    RST_ALL = 1,
    RST_MAC = 2,
    RST_MM  = 3
  } rst_dom_e;

  // Stretch counter and programmed delay
  typedef logic [`RST_CNT_W-1:0] rst_cnt_t;

endpackage

`default_nettype wire

/* rtl/rst_stretch.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_stretch (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    trig,       // Soft-reset pulse
  input  wire rst_ctrl_pkg::rst_cnt_t  delay,      // Shared with other domains
  output logic                         rst_out     // Active-high domain reset
);

  import rst_ctrl_pkg::*;

  logic     flag_q;   // Stretch in progress
  rst_cnt_t cnt_q;    // Cycles since stretch start

  // Set by reset or pulse, cleared once the count reaches the delay
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flag_q <= 1'b1;                            // Domains start in reset
    end else if (trig) begin
      flag_q <= 1'b1;                            // Wins over the clear
    end else if (flag_q && (cnt_q == delay)) begin
      flag_q <= 1'b0;                            // delay+1 cycles elapsed
    end
  end

  // Retrigger keeps counting, so the stretch is not restarted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (flag_q) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      cnt_q <= '0;                               // Idle
    end
  end

  assign rst_out = flag_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f sim.f --top-module cfg_top_wrapper_tb -Mdir obj_dir \
  && ./obj_dir/Vcfg_top_wrapper_tb \
  || exit 1

/* sim.f */
+incdir+rtl
rtl/cfg_reg_pkg.sv
rtl/rst_ctrl_pkg.sv
rtl/rst_stretch.sv
rtl/cfg_regs.sv
rtl/cfg_top_wrapper.sv
verif/tb_clk_gen.sv
verif/cfg_top_wrapper_chk.sv
verif/cfg_top_wrapper_tb.sv

/* verif/cfg_top_wrapper_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_defs.svh"

module cfg_top_wrapper_chk (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire logic                    reg_wr_en,
  input wire logic                    reg_rd_en,
  input wire logic [`CFG_ADDR_W-1:0]  reg_addr,
  input wire cfg_reg_pkg::cfg_word_t  reg_wr_data,
  input wire logic [`CFG_BE_W-1:0]    reg_byte_enable,
  input wire cfg_reg_pkg::cfg_word_t  params_version_num_ro,
  input wire cfg_reg_pkg::cfg_word_t  drop_pkt_cnt,
  input wire cfg_reg_pkg::cfg_word_t  reg_rd_data,
  input wire logic                    reg_rd_data_vld,
  input wire logic                    params_dsp_rst,
  input wire logic                    params_all_rst,
  input wire logic                    params_mac_rst,
  input wire logic                    params_mm_rst,
  input wire logic                    eth_tx_enable,
  input wire logic                    eth_rx_enable,
  input wire logic [3:0]              params_mode_sel,
  input wire logic [15:0]             params_board_id,
  input wire cfg_reg_pkg::cfg_word_t  params_test
);

  import cfg_reg_pkg::*;
  import rst_ctrl_pkg::*;

  int                      fail_cnt = 0;            // Read by the testbench top
  cfg_ctrl_u               ctrl_sh;                 // Shadow control word
  cfg_word_t               test_sh;
  rst_cnt_t                delay_sh;
  logic [`RST_DOM_NUM-1:0] pulse_sh;                // Expected soft-reset pulses
  logic [`RST_DOM_NUM-1:0] flag_sh;                 // Expected stretch levels
  rst_cnt_t                cnt_sh [`RST_DOM_NUM];
  cfg_word_t               rd_exp;
  cfg_word_t               rd_exp_q;                // Expected data one cycle later
  logic [`RST_DOM_NUM-1:0] rst_vec;

  assign rst_vec = {params_mm_rst, params_mac_rst, params_all_rst, params_dsp_rst};

  ////////////////////////////////////////
  // Shadow registers from bus writes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_sh.word <= '0;
      test_sh      <= '0;
      delay_sh     <= rst_cnt_t'(`RST_DELAY_DEF);
      pulse_sh     <= '0;
    end else begin
      pulse_sh <= '0;                                // Pulses last one cycle
      for (int i = 0; i < `CFG_BE_W; i++) begin
        if (reg_wr_en && reg_byte_enable[i] && reg_addr == `REG_CTRL) begin
          ctrl_sh.word[i*8 +: 8] <= reg_wr_data[i*8 +: 8];
        end
        if (reg_wr_en && reg_byte_enable[i] && reg_addr == `REG_TEST) begin
          test_sh[i*8 +: 8] <= reg_wr_data[i*8 +: 8];
        end
      end
      if (reg_wr_en && reg_byte_enable[0] && reg_addr == `REG_RST_DELAY) begin
        delay_sh <= rst_cnt_t'(reg_wr_data[7:0]);    // Low byte only
      end
      if (reg_wr_en && reg_byte_enable[0] && reg_addr == `REG_RST_CMD) begin
        pulse_sh <= reg_wr_data[`RST_DOM_NUM-1:0];
      end
    end
  end

  // Stretch rule per domain
  always_ff @(posedge clk) begin
    for (int d = 0; d < `RST_DOM_NUM; d++) begin
      if (!rst_n) begin
        flag_sh[d] <= 1'b1;
        cnt_sh[d]  <= '0;
      end else begin
        if (pulse_sh[d]) begin
          flag_sh[d] <= 1'b1;                        // Pulse beats the clear
        end else if (flag_sh[d] && cnt_sh[d] == delay_sh) begin
          flag_sh[d] <= 1'b0;
        end
        cnt_sh[d] <= flag_sh[d] ? cnt_sh[d] + rst_cnt_t'(1) : '0;   // No restart
      end
    end
  end

  always_comb begin
    case (reg_addr)
      `REG_VERSION:   rd_exp = params_version_num_ro;
      `REG_CTRL:      rd_exp = ctrl_sh.word;
      `REG_RST_DELAY: rd_exp = cfg_word_t'(delay_sh);
      `REG_DROP_CNT:  rd_exp = drop_pkt_cnt;
      `REG_TEST:      rd_exp = test_sh;
      default:        rd_exp = '0;                   // Command reg and unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    rd_exp_q <= rd_exp;
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_idle_in_reset: assert property (@(posedge clk)
    !rst_n |-> !reg_wr_en && !reg_rd_en && !reg_rd_data_vld)
    else begin
      fail_cnt++;
      $error("Bus strobe or read valid active during reset");
    end

  a_rd_vld: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rd_data_vld == $past(reg_rd_en))
    else begin
      fail_cnt++;
      $error("CHECK FAILED reg_rd_data_vld got %h", reg_rd_data_vld);
    end

  a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
    $past(reg_rd_en) |-> reg_rd_data == rd_exp_q)
    else begin
      fail_cnt++;
      $error("CHECK FAILED reg_rd_data got %h exp %h", reg_rd_data, rd_exp_q);
    end

  a_ctrl_fields: assert property (@(posedge clk)
    {params_board_id, params_mode_sel, eth_rx_enable, eth_tx_enable} ==
    {ctrl_sh.fields.board_id, ctrl_sh.fields.mode_sel,
     ctrl_sh.fields.eth_rx_enable, ctrl_sh.fields.eth_tx_enable})
    else begin
      fail_cnt++;
      $error("CHECK FAILED ctrl fields got %h/%h/%h/%h exp word %h", params_board_id,
             params_mode_sel, eth_rx_enable, eth_tx_enable, ctrl_sh.word);
    end

  a_test_word: assert property (@(posedge clk) params_test == test_sh)
    else begin
      fail_cnt++;
      $error("CHECK FAILED params_test got %h exp %h", params_test, test_sh);
    end

  // Covers the 17-cycle release and the D+1 stretches
  a_rst_levels: assert property (@(posedge clk) rst_vec == flag_sh)
    else begin
      fail_cnt++;
      $error("CHECK FAILED rst_vec got %h exp %h", rst_vec, flag_sh);
    end

endmodule

bind cfg_top_wrapper cfg_top_wrapper_chk u_chk (.*);

`default_nettype wire

/* verif/cfg_top_wrapper_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_defs.svh"

module cfg_top_wrapper_tb;

  import cfg_reg_pkg::*;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_wr_en;
  logic                   reg_rd_en;
  logic [`CFG_ADDR_W-1:0] reg_addr;
  cfg_word_t              reg_wr_data;
  logic [`CFG_BE_W-1:0]   reg_byte_enable;
  cfg_word_t              params_version_num_ro;
  cfg_word_t              drop_pkt_cnt;
  cfg_word_t              reg_rd_data;
  logic                   reg_rd_data_vld;
  logic                   params_dsp_rst;
  logic                   params_all_rst;
  logic                   params_mac_rst;
  logic                   params_mm_rst;
  logic                   eth_tx_enable;
  logic                   eth_rx_enable;
  logic [3:0]             params_mode_sel;
  logic [15:0]            params_board_id;
  cfg_word_t              params_test;
  logic [3:0]             rst_vec;
  int                     delay_d;

  assign rst_vec = {params_mm_rst, params_mac_rst, params_all_rst, params_dsp_rst};

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cfg_top_wrapper cfg_top_wrapper_i (.*);

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  task automatic bus_write(input logic [`CFG_ADDR_W-1:0] addr, input cfg_word_t data,
                           input logic [`CFG_BE_W-1:0] be);
    @(posedge clk);
    reg_wr_en       <= 1'b1;
    reg_addr        <= addr;
    reg_wr_data     <= data;
    reg_byte_enable <= be;
    @(posedge clk);
    reg_wr_en       <= 1'b0;
  endtask

  // Data is compared by the bound checker
  task automatic bus_read(input logic [`CFG_ADDR_W-1:0] addr);
    int n;
    n = 0;
    @(posedge clk);
    reg_rd_en <= 1'b1;
    reg_addr  <= addr;
    @(posedge clk);
    reg_rd_en <= 1'b0;
    @(negedge clk);
    while (!reg_rd_data_vld) begin
      n++;
      if (n > 8) begin
        $display("Read valid never arrived for address %h", addr);
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
      @(negedge clk);
    end
  endtask

  // Stretch starts one cycle after the command edge
  task automatic wait_rst_low(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    @(negedge clk);
    while (rst_vec != 4'h0) begin
      n++;
      if (n > limit) begin
        $display("Domain resets stuck high at %h", rst_vec);
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
      @(negedge clk);
    end
  endtask

  // First assertion failure ends the run
  always @(negedge clk) begin
    if (cfg_top_wrapper_i.u_chk.fail_cnt != 0) begin
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  initial begin
    int n;
    void'($urandom(76));
    reg_wr_en             = 1'b0;
    reg_rd_en             = 1'b0;
    reg_addr              = '0;
    reg_wr_data           = '0;
    reg_byte_enable       = '0;
    params_version_num_ro = 32'h0001_0203;
    drop_pkt_cnt          = $urandom;
    n = 0;
    while (rst_n !== 1'b1) begin
      n++;
      if (n > 40) begin
        $display("Reset never released");
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
      @(posedge clk);
    end
    wait_rst_low(`RST_DELAY_DEF + 8);                  // Power-on stretch

    // Whole map plus unmapped holes
    bus_read(`REG_VERSION);
    bus_read(`REG_CTRL);
    bus_read(`REG_RST_DELAY);
    bus_read(`REG_RST_CMD);
    bus_read(`REG_DROP_CNT);
    bus_read(`REG_TEST);
    bus_read(14'h018);
    bus_read(14'h3FFC);

    // Random lane writes
    for (int i = 0; i < 24; i++) begin
      bus_write((i % 2 == 0) ? `REG_CTRL : `REG_TEST, $urandom, 4'($urandom));
      bus_read((i % 2 == 0) ? `REG_CTRL : `REG_TEST);
    end
    bus_write(14'h01C, $urandom, 4'hF);                // Ignored write
    bus_read(`REG_TEST);

    delay_d = int'($urandom_range(2, 20));             // Retrigger lands before the clear
    bus_write(`REG_RST_DELAY, 32'(delay_d), 4'h1);
    bus_read(`REG_RST_DELAY);

    // One domain at a time
    for (int k = 0; k < `RST_DOM_NUM; k++) begin
      bus_write(`REG_RST_CMD, 32'(1 << k), 4'h1);
      wait_rst_low(delay_d + 8);
    end

    // Retrigger mid-stretch
    bus_write(`REG_RST_CMD, 32'h1, 4'h1);
    bus_write(`REG_RST_CMD, 32'h1, 4'h1);
    wait_rst_low(delay_d + 8);

    // Several domains, then a command without lane 0
    bus_write(`REG_RST_CMD, 32'($urandom_range(1, 15)), 4'h1);
    wait_rst_low(delay_d + 8);
    bus_write(`REG_RST_CMD, 32'hF, 4'hE);
    bus_read(`REG_RST_CMD);
    repeat (4) @(posedge clk);

    if (cfg_top_wrapper_i.u_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 20,     // 40 ns clock
  parameter int RST_CYCLES  = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Synchronous release on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire
